/* source/cmd_consts.svh */
`ifndef CMD_CONSTS_SVH
`define CMD_CONSTS_SVH

// stream word and command field
`define CMD_WORD_W        32
`define CMD_CODE_W        5

// command codes, low bits of the command word
`define CC_LOOPBACK       5'd1
`define CC_RD_REG         5'd2
`define CC_WR_REG         5'd3

// register numbers, 0..4 read/write, 5 and 6 read only
`define REG_NUM_W         4
`define REG_CHANNEL_TAG   4'd0
`define REG_MUON_BURSTS   4'd1
`define REG_LASER_BURSTS  4'd2
`define REG_PED_BURSTS    4'd3
`define REG_INIT_FILL_NUM 4'd4
`define REG_CH_ADDR       4'd5
`define REG_FILL_NUM      4'd6

// register field widths
`define TAG_W             16
`define BURST_W           23
`define FILL_W            24
`define CH_ADDR_W         3

`endif

/* source/cmd_pkg.sv */
`default_nettype none

`include "cmd_consts.svh"

package cmd_pkg;

	typedef logic [`CMD_WORD_W-1:0] word_t;     // one stream word
	typedef logic [`REG_NUM_W-1:0]  reg_num_t;  // register number field
	typedef logic [`TAG_W-1:0]      tag_t;
	typedef logic [`BURST_W-1:0]    burst_t;
	typedef logic [`FILL_W-1:0]     fill_t;
	typedef logic [`CH_ADDR_W-1:0]  ch_addr_t;

	// decoded command, anything not listed maps to unknown
	typedef enum logic [`CMD_CODE_W-1:0] {
		CODE_UNKNOWN  = 5'd0,
		CODE_LOOPBACK = `CC_LOOPBACK,
		CODE_RD_REG   = `CC_RD_REG,
		CODE_WR_REG   = `CC_WR_REG
	} cmd_code_e;

	// latched frame header
	typedef struct packed {
		word_t csn;  // serial number word
		word_t cmd;  // command word
	} cmd_hdr_t;

	// source of the next response word
	typedef enum logic [2:0] {
		SEL_CSN,
		SEL_CMD,
		SEL_INV_CMD,
		SEL_RX_DATA,
		SEL_REG_DATA
	} tx_sel_e;

	typedef struct packed {
		logic    load;  // take a new word into the tx register
		tx_sel_e sel;
		logic    last;  // word closes the response frame
	} tx_ctrl_t;

	typedef struct packed {
		reg_num_t num;
		word_t    wr_data;
		logic     rd;
		logic     wr;
	} reg_req_t;

	// settings for the acquisition logic
	typedef struct packed {
		tag_t   channel_tag;
		burst_t num_muon_bursts;
		burst_t num_laser_bursts;
		burst_t num_ped_bursts;
		fill_t  initial_fill_num;
	} acq_settings_t;

endpackage

`default_nettype wire

/* source/cmd_register_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_consts.svh"

module cmd_register_bank
	import cmd_pkg::*;
(
	input  wire           clk,
	input  wire           reset,
	input  wire reg_req_t req,
	input  wire fill_t    fill_num,             // current fill number is read only
	input  wire ch_addr_t ch_addr,              // read only jumpers
	output word_t         rd_data,
	output logic          illegal,
	output acq_settings_t settings,
	output logic          initial_fill_num_wr   // one cycle per write of reg 4
);

	ch_addr_t ch_addr_q;  // corrected jumpers

	// beyond the last register or a write above the r/w range
	assign illegal = (req.num > `REG_FILL_NUM) ||
		(req.wr && (req.num > `REG_INIT_FILL_NUM));

	//////////////////////////////////////////////////
	// channel 3 board has its jumpers set to 110
	always_ff @(posedge clk) begin
		if (ch_addr == 3'b110)
			ch_addr_q <= 3'b011;
		else
			ch_addr_q <= ch_addr;
	end

	//////////////////////////////////////////////////
	// read/write registers
	always_ff @(posedge clk) begin
		if (reset) begin
			settings            <= '0;
			initial_fill_num_wr <= 1'b0;
		end else begin
			initial_fill_num_wr <= req.wr && !illegal && (req.num == `REG_INIT_FILL_NUM);
			if (req.wr && !illegal) begin
				case (req.num)
					`REG_CHANNEL_TAG:   settings.channel_tag      <= req.wr_data[`TAG_W-1:0];
					`REG_MUON_BURSTS:   settings.num_muon_bursts  <= req.wr_data[`BURST_W-1:0];
					`REG_LASER_BURSTS:  settings.num_laser_bursts <= req.wr_data[`BURST_W-1:0];
					`REG_PED_BURSTS:    settings.num_ped_bursts   <= req.wr_data[`BURST_W-1:0];
					`REG_INIT_FILL_NUM: settings.initial_fill_num <= req.wr_data[`FILL_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// zero extended read back valid the cycle after the strobe
	always_ff @(posedge clk) begin
		if (req.rd && !illegal) begin
			case (req.num)
				`REG_CHANNEL_TAG:   rd_data <= word_t'(settings.channel_tag);
				`REG_MUON_BURSTS:   rd_data <= word_t'(settings.num_muon_bursts);
				`REG_LASER_BURSTS:  rd_data <= word_t'(settings.num_laser_bursts);
				`REG_PED_BURSTS:    rd_data <= word_t'(settings.num_ped_bursts);
				`REG_INIT_FILL_NUM: rd_data <= word_t'(settings.initial_fill_num);
				`REG_CH_ADDR:       rd_data <= word_t'(ch_addr_q);
				`REG_FILL_NUM:      rd_data <= word_t'(fill_num);
				default:            rd_data <= '0;
			endcase
		end
	end

	a_fill_wr_single: assert property (@(posedge clk) disable iff (reset)
		initial_fill_num_wr |=> !initial_fill_num_wr)
		else $error("initial fill strobe longer than one cycle");

endmodule

`default_nettype wire

/* source/cmd_frame_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_consts.svh"

module cmd_frame_decode
	import cmd_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  wire        rx_tvalid,
	input  wire        rx_tlast,
	input  wire word_t rx_data,
	input  wire        body_take,        // execute wants a body word
	input  wire        done,             // execute finished the frame
	output logic       rx_tready,
	output logic       run,              // one cycle pulse that starts execute
	output cmd_code_e  code,
	output cmd_hdr_t   hdr,
	output logic       command_sm_idle
);

	typedef enum logic [1:0] {
		ST_IDLE,     // waiting for the serial number word
		ST_COMMAND,  // waiting for the command word
		ST_BUSY      // execute owns the frame
	} dec_state_e;

	dec_state_e state;

	// map the low bits of the command word onto the known codes
	function automatic cmd_code_e decode_code(input logic [`CMD_CODE_W-1:0] field);
		cmd_code_e result;
		case (field)
			`CC_LOOPBACK: result = CODE_LOOPBACK;
			`CC_RD_REG:   result = CODE_RD_REG;
			`CC_WR_REG:   result = CODE_WR_REG;
			default:      result = CODE_UNKNOWN;
		endcase
		return result;
	endfunction

	//////////////////////////////////////////////////
	// header FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			run   <= 1'b0;
			code  <= CODE_UNKNOWN;
			hdr   <= '0;
		end else begin
			run <= 1'b0;  // pulse only
			case (state)
				ST_IDLE: begin
					if (rx_tvalid) begin
						hdr.csn <= rx_data;  // serial number
						state   <= ST_COMMAND;
					end
				end
				ST_COMMAND: begin
					if (rx_tvalid) begin
						hdr.cmd <= rx_data;
						code    <= decode_code(rx_data[`CMD_CODE_W-1:0]);
						run     <= 1'b1;  // lands one cycle after the command word
						state   <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					if (done)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// header words always taken and body words only on request
	assign rx_tready       = (state != ST_BUSY) || body_take;
	assign command_sm_idle = (state == ST_IDLE);

	//////////////////////////////////////////////////
	// checks
	a_take_while_busy: assert property (@(posedge clk) disable iff (reset)
		body_take |-> state == ST_BUSY)
		else $error("body word requested outside a frame body");

endmodule

`default_nettype wire

/* source/cmd_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_consts.svh"

module cmd_execute
	import cmd_pkg::*;
(
	input  wire            clk,
	input  wire            reset,
	input  wire            run,
	input  wire cmd_code_e code,
	input  wire            rx_tvalid,
	input  wire            rx_tlast,
	input  wire word_t     rx_data,
	input  wire            tx_busy,           // tx register holds an unsent word
	input  wire fill_t     fill_num,
	input  wire ch_addr_t  ch_addr,
	output logic           body_take,
	output logic           done,
	output tx_ctrl_t       tx_ctrl,
	output word_t          rx_word,           // last body word taken for loopback
	output word_t          reg_word,
	output acq_settings_t  settings,
	output logic           initial_fill_num_wr
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_DRAIN,    // unknown code so swallow body up to tlast
		S_CSN,
		S_NUM,      // register number word
		S_DATA,     // write data word
		S_CMD,      // cmd or inverted cmd
		S_VAL,      // register value
		S_LB_TAKE,  // take one loopback body word
		S_LB_ECHO,  // send the loopback word back
		S_WAIT      // last word out and waiting for acceptance
	} exec_state_e;

	exec_state_e state, state_nxt;
	reg_num_t    num_q;
	word_t       wr_data_q;
	logic        last_q;      // echoed word carried tlast
	logic        is_reg_cmd;
	logic        cmd_load;
	logic        illegal;
	logic        err;         // error reply instead of cmd
	reg_req_t    req;

	assign is_reg_cmd = (code == CODE_RD_REG) || (code == CODE_WR_REG);
	assign cmd_load   = (state == S_CMD) && !tx_busy;

	// strobes fire together with the cmd word so the bank check sees the write
	assign req = '{
		num:     num_q,
		wr_data: wr_data_q,
		rd:      cmd_load && (code == CODE_RD_REG),
		wr:      cmd_load && (code == CODE_WR_REG)
	};

	assign err = (code == CODE_UNKNOWN) || (is_reg_cmd && illegal);

	cmd_register_bank bank (
		.clk                 (clk),
		.reset               (reset),
		.req                 (req),
		.fill_num            (fill_num),
		.ch_addr             (ch_addr),
		.rd_data             (reg_word),
		.illegal             (illegal),
		.settings            (settings),
		.initial_fill_num_wr (initial_fill_num_wr)
	);

	//////////////////////////////////////////////////
	// per frame sequencer
	always_comb begin
		state_nxt = state;
		body_take = 1'b0;
		done      = 1'b0;
		tx_ctrl   = '0;
		case (state)
			S_IDLE: if (run) state_nxt = (code == CODE_UNKNOWN) ? S_DRAIN : S_CSN;
			S_DRAIN: begin
				body_take = 1'b1;
				if (rx_tvalid && rx_tlast)
					state_nxt = S_CSN;
			end
			S_CSN: begin
				if (!tx_busy) begin
					tx_ctrl.load = 1'b1;
					tx_ctrl.sel  = SEL_CSN;
					state_nxt    = is_reg_cmd ? S_NUM : S_CMD;
				end
			end
			S_NUM: begin
				body_take = 1'b1;
				if (rx_tvalid)
					state_nxt = (code == CODE_WR_REG) ? S_DATA : S_CMD;
			end
			S_DATA: begin
				body_take = 1'b1;
				if (rx_tvalid)
					state_nxt = S_CMD;
			end
			S_CMD: begin
				if (cmd_load) begin
					tx_ctrl.load = 1'b1;
					tx_ctrl.sel  = err ? SEL_INV_CMD : SEL_CMD;
					if (err || code == CODE_WR_REG) begin
						tx_ctrl.last = 1'b1;  // reply ends here
						state_nxt    = S_WAIT;
					end else if (code == CODE_RD_REG)
						state_nxt = S_VAL;
					else
						state_nxt = S_LB_TAKE;
				end
			end
			S_VAL: begin
				if (!tx_busy) begin  // read data settled long ago
					tx_ctrl.load = 1'b1;
					tx_ctrl.sel  = SEL_REG_DATA;
					tx_ctrl.last = 1'b1;
					state_nxt    = S_WAIT;
				end
			end
			S_LB_TAKE: begin
				body_take = !tx_busy;  // hold the master off while an echo is pending
				if (body_take && rx_tvalid)
					state_nxt = S_LB_ECHO;
			end
			S_LB_ECHO: begin
				if (!tx_busy) begin
					tx_ctrl.load = 1'b1;
					tx_ctrl.sel  = SEL_RX_DATA;
					tx_ctrl.last = last_q;
					state_nxt    = last_q ? S_WAIT : S_LB_TAKE;
				end
			end
			S_WAIT: begin
				if (!tx_busy) begin  // final word accepted
					done      = 1'b1;
					state_nxt = S_IDLE;
				end
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= S_IDLE;
			last_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (state == S_LB_TAKE && body_take && rx_tvalid)
				last_q <= rx_tlast;
		end
	end

	// body word payload
	always_ff @(posedge clk) begin
		if (body_take && rx_tvalid) begin
			case (state)
				// out of range numbers fold onto an illegal one
				S_NUM:     num_q <= (|rx_data[`CMD_WORD_W-1:`REG_NUM_W]) ?
					'1 : rx_data[`REG_NUM_W-1:0];
				S_DATA:    wr_data_q <= rx_data;
				S_LB_TAKE: rx_word   <= rx_data;
				default: ;
			endcase
		end
	end

	a_run_when_idle: assert property (@(posedge clk) disable iff (reset)
		run |-> state == S_IDLE)
		else $error("run pulse while a frame is still in progress");

endmodule

`default_nettype wire

/* source/cmd_result.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_result
	import cmd_pkg::*;
(
	input  wire           clk,
	input  wire           reset,
	input  wire tx_ctrl_t ctrl,
	input  wire cmd_hdr_t hdr,
	input  wire word_t    rx_word,
	input  wire word_t    reg_word,
	input  wire           tx_tready,
	output word_t         tx_data,
	output logic          tx_tvalid,
	output logic          tx_tlast,
	output logic          tx_busy
);

	word_t word_nxt;

	// response word mux
	always_comb begin
		case (ctrl.sel)
			SEL_CSN:      word_nxt = hdr.csn;
			SEL_CMD:      word_nxt = hdr.cmd;
			SEL_INV_CMD:  word_nxt = ~hdr.cmd;   // error reply
			SEL_RX_DATA:  word_nxt = rx_word;    // loopback echo
			SEL_REG_DATA: word_nxt = reg_word;
			default:      word_nxt = hdr.cmd;
		endcase
	end

	//////////////////////////////////////////////////
	// tx register, held until the slave takes it
	always_ff @(posedge clk) begin
		if (ctrl.load)
			tx_data <= word_nxt;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			tx_tvalid <= 1'b0;
			tx_tlast  <= 1'b0;
		end else if (ctrl.load) begin
			tx_tvalid <= 1'b1;
			tx_tlast  <= ctrl.last;
		end else if (tx_tvalid && tx_tready) begin  // transferred
			tx_tvalid <= 1'b0;
			tx_tlast  <= 1'b0;
		end
	end

	assign tx_busy = tx_tvalid;

	a_stable_backpressure: assert property (@(posedge clk) disable iff (reset)
		tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_data) && $stable(tx_tlast))
		else $error("tx word changed while stalled");

endmodule

`default_nettype wire

/* source/command_top.sv */
`timescale 1ns/1ps
`default_nettype none

module command_top
	import cmd_pkg::*;
(
	input  wire           clk,
	input  wire           reset,
	// receive stream from the master
	input  wire word_t    rx_data,
	input  wire           rx_tvalid,
	input  wire           rx_tlast,
	output logic          rx_tready,
	// transmit stream to the master
	output word_t         tx_data,
	output logic          tx_tvalid,
	output logic          tx_tlast,
	input  wire           tx_tready,
	// acquisition side
	input  wire fill_t    fill_num,
	input  wire ch_addr_t ch_addr,
	output acq_settings_t settings,
	output logic          initial_fill_num_wr,
	output logic          command_sm_idle     // front panel LED
);

	logic      run, done, body_take, tx_busy;
	cmd_code_e code;
	cmd_hdr_t  hdr;
	tx_ctrl_t  tx_ctrl;
	word_t     rx_word, reg_word;

	//////////////////////////////////////////////////
	// header and dispatch
	cmd_frame_decode decode (
		.clk(clk), .reset(reset),
		.rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_data(rx_data),
		.body_take(body_take), .done(done),
		.rx_tready(rx_tready),
		.run(run), .code(code), .hdr(hdr),
		.command_sm_idle(command_sm_idle)
	);

	// command sequencing and register bank
	cmd_execute execute (
		.clk(clk), .reset(reset),
		.run(run), .code(code),
		.rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_data(rx_data),
		.tx_busy(tx_busy),
		.fill_num(fill_num), .ch_addr(ch_addr),
		.body_take(body_take), .done(done),
		.tx_ctrl(tx_ctrl), .rx_word(rx_word), .reg_word(reg_word),
		.settings(settings), .initial_fill_num_wr(initial_fill_num_wr)
	);

	// response words onto the tx stream
	cmd_result result (
		.clk(clk), .reset(reset),
		.ctrl(tx_ctrl), .hdr(hdr), .rx_word(rx_word), .reg_word(reg_word),
		.tx_tready(tx_tready),
		.tx_data(tx_data), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast),
		.tx_busy(tx_busy)
	);

endmodule

`default_nettype wire

/* testbench/command_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmd_consts.svh"

module command_top_tb
	import cmd_pkg::*;
();

	// one request frame, body[0] goes out first
	typedef struct packed {
		word_t       csn;
		word_t       cmd;
		word_t [3:0] body;
		int          n_body;
		fill_t       fill_num;   // acquisition side inputs during the frame
		ch_addr_t    ch_addr;
	} frame_t;

	logic          clk, reset;
	word_t         rx_data;
	logic          rx_tvalid, rx_tlast, rx_tready;
	word_t         tx_data;
	logic          tx_tvalid, tx_tlast, tx_tready;
	fill_t         fill_num;
	ch_addr_t      ch_addr;
	acq_settings_t settings;
	logic          initial_fill_num_wr, command_sm_idle;

	frame_t        frames [$];
	acq_settings_t model;            // expected register contents
	word_t         exp_words [0:5];  // expected reply of the current frame
	int            exp_len, exp_pulses;
	int            error_count, check_count, frames_passed, frames_failed;
	int            cycle_count = 0;
	int            cycle_limit = 0;
	int unsigned   seed_ret;

	command_top uut (
		.clk(clk), .reset(reset),
		.rx_data(rx_data), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tready(rx_tready),
		.tx_data(tx_data), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tready(tx_tready),
		.fill_num(fill_num), .ch_addr(ch_addr),
		.settings(settings), .initial_fill_num_wr(initial_fill_num_wr),
		.command_sm_idle(command_sm_idle)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 25 MHz
	end

	// watchdog, limit set once the table is known
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// frame table
	task automatic add_frame(input word_t csn, input word_t cmd, input int n_body,
		input word_t b0, input word_t b1, input word_t b2, input word_t b3,
		input fill_t fill, input ch_addr_t ch);
		frame_t f;
		f = '{csn, cmd, {b3, b2, b1, b0}, n_body, fill, ch};
		frames.push_back(f);
	endtask

	task automatic fill_table();
		// loopback, one to four body words, upper cmd bits are don't care
		add_frame(32'h0000_0100, 32'ha5a5_0001, 1, 32'h1111_0000, 0, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0101, 32'h0000_0021, 2, 32'h2222_0001, 32'h2222_0002, 0, 0,
			24'h0, 3'h0);
		add_frame(32'h0000_0102, 32'hffff_ffe1, 3, 32'h3333_0001, 32'h3333_0002,
			32'h3333_0003, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0103, 32'h0000_0001, 4, 32'h4444_0001, 32'h4444_0002,
			32'h4444_0003, 32'h4444_0004, 24'h0, 3'h0);
		// writes, data wider than the fields
		add_frame(32'h0000_0200, 32'h0000_0003, 2, 32'd0, 32'hdead_beef, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0201, 32'h0000_0003, 2, 32'd1, 32'hffff_ffff, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0202, 32'h0000_0003, 2, 32'd2, 32'h0012_3456, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0203, 32'h0000_0003, 2, 32'd3, 32'h80ab_cdef, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0204, 32'h0000_0003, 2, 32'd4, 32'h5a12_3456, 0, 0, 24'h0, 3'h0);
		// read back
		add_frame(32'h0000_0300, 32'h0100_0002, 1, 32'd0, 0, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0301, 32'h0100_0002, 1, 32'd1, 0, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0302, 32'h0100_0002, 1, 32'd2, 0, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0303, 32'h0100_0002, 1, 32'd3, 0, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0304, 32'h0100_0002, 1, 32'd4, 0, 0, 0, 24'h0, 3'h0);
		// read only registers
		add_frame(32'h0000_0400, 32'h0000_0002, 1, 32'd6, 0, 0, 0, 24'habcdef, 3'h0);
		add_frame(32'h0000_0401, 32'h0000_0002, 1, 32'd5, 0, 0, 0, 24'h0, 3'b110);
		add_frame(32'h0000_0402, 32'h0000_0002, 1, 32'd5, 0, 0, 0, 24'h0, 3'b101);
		// error replies
		add_frame(32'h0000_0500, 32'h0000_0002, 1, 32'd9, 0, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0501, 32'h0000_0003, 2, 32'd5, 32'h0000_0007, 0, 0, 24'h0, 3'h0);
		add_frame(32'h0000_0502, 32'h00c0_0007, 2, 32'h7777_0001, 32'h7777_0002, 0, 0,
			24'h0, 3'h0);
		add_frame(32'h0000_0503, 32'h0000_0002, 1, 32'h0001_0002, 0, 0, 0, 24'h0, 3'h0);
		// still alive afterwards
		add_frame(32'h0000_0600, 32'h0000_0001, 2, 32'h8888_0001, 32'h8888_0002, 0, 0,
			24'h0, 3'h0);
		add_frame(32'h0000_0601, 32'h0000_0002, 1, 32'd4, 0, 0, 0, 24'h0, 3'h0);
	endtask

	//////////////////////////////////////////////////
	// reference model
	function automatic word_t read_value(input word_t num, input frame_t f);
		word_t    v;
		ch_addr_t ch;
		ch = (f.ch_addr == 3'b110) ? 3'b011 : f.ch_addr;  // channel 3 jumper fix
		case (num)
			32'd0:   v = {16'h0, model.channel_tag};
			32'd1:   v = {9'h0, model.num_muon_bursts};
			32'd2:   v = {9'h0, model.num_laser_bursts};
			32'd3:   v = {9'h0, model.num_ped_bursts};
			32'd4:   v = {8'h0, model.initial_fill_num};
			32'd5:   v = {29'h0, ch};
			default: v = {8'h0, f.fill_num};  // current fill
		endcase
		return v;
	endfunction

	task automatic expect_reply(input frame_t f);
		logic [`CMD_CODE_W-1:0] code;
		word_t                  num;
		int                     i;
		code = f.cmd[`CMD_CODE_W-1:0];
		num = f.body[0];
		exp_words[0] = f.csn;
		exp_words[1] = f.cmd;
		exp_len = 2;
		exp_pulses = 0;
		if (code == `CC_LOOPBACK) begin
			for (i = 0; i < f.n_body; i++)
				exp_words[2 + i] = f.body[i];  // echoes in order
			exp_len = 2 + f.n_body;
		end else if (code == `CC_RD_REG && num <= 32'd6) begin
			exp_words[2] = read_value(num, f);
			exp_len = 3;
		end else if (code == `CC_WR_REG && num <= 32'd4) begin
			case (num)
				32'd0:   model.channel_tag = f.body[1][`TAG_W-1:0];
				32'd1:   model.num_muon_bursts = f.body[1][`BURST_W-1:0];
				32'd2:   model.num_laser_bursts = f.body[1][`BURST_W-1:0];
				32'd3:   model.num_ped_bursts = f.body[1][`BURST_W-1:0];
				default: model.initial_fill_num = f.body[1][`FILL_W-1:0];
			endcase
			if (num == 32'd4)
				exp_pulses = 1;  // fill strobe expected
		end else
			exp_words[1] = ~f.cmd;  // error reply
	endtask

	function automatic string frame_kind(input word_t cmd);
		string s;
		case (cmd[`CMD_CODE_W-1:0])
			`CC_LOOPBACK: s = "loopback";
			`CC_RD_REG:   s = "read";
			`CC_WR_REG:   s = "write";
			default:      s = "unknown";
		endcase
		return s;
	endfunction

	//////////////////////////////////////////////////
	// checks
	task automatic check_word(input int idx, input int pos, input word_t data, input logic last);
		check_count++;
		if (pos >= exp_len) begin
			$display("frame %0d: extra response word %h after the reply", idx, data);
			error_count++;
		end else begin
			if (data !== exp_words[pos]) begin
				$display("MISMATCH at %0d ns: frame %0d word %0d is %h, expected %h",
					$time, idx, pos, data, exp_words[pos]);
				error_count++;
			end
			if (last !== (pos == exp_len - 1)) begin
				$display("MISMATCH at %0d ns: frame %0d word %0d tlast is %b",
					$time, idx, pos, last);
				error_count++;
			end
		end
	endtask

	task automatic check_reset();
		int errs_before;
		errs_before = error_count;
		check_count++;
		if (tx_tvalid !== 1'b0 || tx_tlast !== 1'b0 || initial_fill_num_wr !== 1'b0) begin
			$display("MISMATCH at %0d ns: tx or fill strobe active after reset", $time);
			error_count++;
		end
		if (rx_tready !== 1'b1 || command_sm_idle !== 1'b1) begin
			$display("MISMATCH at %0d ns: rx_tready or idle low after reset", $time);
			error_count++;
		end
		if (settings !== '0) begin
			$display("MISMATCH at %0d ns: settings %h after reset", $time, settings);
			error_count++;
		end
		$display("reset values: %s", (error_count == errs_before) ? "ok" : "failed");
	endtask

	//////////////////////////////////////////////////
	// one frame out, reply collected, all at falling edges
	task automatic run_frame(input int idx, input frame_t f);
		word_t req_words [0:5];
		int    n_rx, rx_pos, tx_pos, pulses, wait_cycles, errs_before, i;
		logic  rx_fire, tx_fire, got_last, w_last;
		word_t w_data;
		errs_before = error_count;
		expect_reply(f);
		req_words[0] = f.csn;
		req_words[1] = f.cmd;
		for (i = 0; i < f.n_body; i++)
			req_words[2 + i] = f.body[i];
		n_rx = 2 + f.n_body;
		fill_num = f.fill_num;
		ch_addr = f.ch_addr;
		rx_pos = 0;
		tx_pos = 0;
		pulses = 0;
		got_last = 1'b0;
		while (!got_last) begin
			rx_tvalid = (rx_pos < n_rx);
			if (rx_pos < n_rx)
				rx_data = req_words[rx_pos];
			rx_tlast = (rx_pos == n_rx - 1);
			tx_tready = ($urandom % 3) != 0;  // stall about a third of the time
			// ready and valid here hold through the next rising edge
			rx_fire = rx_tvalid && rx_tready;
			tx_fire = tx_tvalid && tx_tready;
			w_data = tx_data;
			w_last = tx_tlast;
			@(negedge clk);
			if (initial_fill_num_wr)
				pulses++;
			if (rx_fire)
				rx_pos++;
			if (tx_fire) begin
				check_word(idx, tx_pos, w_data, w_last);
				tx_pos++;
				got_last = w_last;
			end
		end
		rx_tvalid = 1'b0;
		rx_tlast = 1'b0;
		if (rx_pos != n_rx || tx_pos != exp_len) begin
			$display("frame %0d: %0d of %0d words taken, %0d of %0d words answered",
				idx, rx_pos, n_rx, tx_pos, exp_len);
			error_count++;
		end
		if (pulses != exp_pulses) begin
			$display("MISMATCH at %0d ns: frame %0d gave %0d fill strobes, expected %0d",
				$time, idx, pulses, exp_pulses);
			error_count++;
		end
		if (settings !== model) begin
			$display("MISMATCH at %0d ns: frame %0d settings %h, expected %h",
				$time, idx, settings, model);
			error_count++;
		end
		wait_cycles = 0;
		while (!command_sm_idle && wait_cycles < 4) begin  // back to idle after done
			@(negedge clk);
			wait_cycles++;
		end
		if (!command_sm_idle) begin
			$display("frame %0d: decoder did not return to idle", idx);
			error_count++;
		end
		if (error_count == errs_before)
			frames_passed++;
		else
			frames_failed++;
		$display("frame %0d %s: %0d words back, %s", idx, frame_kind(f.cmd), tx_pos,
			(error_count == errs_before) ? "ok" : "failed");
	endtask

	//////////////////////////////////////////////////
	initial begin
		int i;
		int total_words;
		seed_ret = $urandom(32'h38a94388);  // single seed for the run
		reset = 1'b1;
		rx_data = '0;
		rx_tvalid = 1'b0;
		rx_tlast = 1'b0;
		tx_tready = 1'b0;
		fill_num = '0;
		ch_addr = '0;
		model = '0;
		error_count = 0;
		check_count = 0;
		frames_passed = 0;
		frames_failed = 0;
		fill_table();
		total_words = 0;
		for (i = 0; i < frames.size(); i++)
			total_words += 2 + frames[i].n_body;
		cycle_limit = 50 * total_words + 100;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		check_reset();
		for (i = 0; i < frames.size(); i++)
			run_frame(i, frames[i]);
		$display("frames %0d, passed %0d, failed %0d, word checks %0d, errors %0d",
			frames.size(), frames_passed, frames_failed, check_count, error_count);
		if (error_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+source
source/cmd_pkg.sv
source/cmd_register_bank.sv
source/cmd_frame_decode.sv
source/cmd_execute.sv
source/cmd_result.sv
source/command_top.sv
testbench/command_top_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = command_top_tb
FILELIST  = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
